// ==== sim.f ====
design/calc_pkg.sv
design/key_decoder.sv
design/calc_ctrl.sv
design/term_alu.sv
design/bin_to_bcd.sv
design/calc_top.sv
dv/calc_assert.sv
dv/calc_tb.sv

// ==== Makefile ====
TOP = calc_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@! grep -q "TB FAILED" sim.log
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/calc_tb.sv ====
`default_nettype none

module calc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD   = 100;
    localparam int NUM_ROWS = 8;
    // per row up to 40 presses of 4 cycles, one long hold, conversion and stall
    localparam int ROW_CYCLES = 40 * 4 + 30 + 40 + 20;
    localparam int MARGIN     = 100;
    localparam int TIMEOUT    = NUM_ROWS * ROW_CYCLES + MARGIN;

    localparam int T_SUM  = 0;
    localparam int T_SUB  = 1;
    localparam int T_MUL  = 2;
    localparam int T_DIV  = 3;
    localparam int T_EQU  = 4;
    localparam int T_NONE = 5;
    localparam int RANDOM_STALL = -1;

    typedef struct {
        int unsigned a;
        int          op1;
        int unsigned b;
        int          op2;
        int unsigned c;
        bit          sticky;
        int          hold;
        bit          junk;
        int          stall;
        int          expv;
    } row_t;

    logic                  rst;
    logic                  clk_100hz;
    calc_pkg::digit_keys_t swp;
    calc_pkg::op_keys_t    swd;
    logic                  res_ready;
    logic                  res_valid;
    logic                  res_sign;
    calc_pkg::bcd_t        res_bcd;

    row_t        rows [NUM_ROWS];
    integer      seed;
    int          errors;
    int          checks;
    int          cycles;
    // reference model of the calculator
    logic [31:0] m_acc;
    logic [31:0] m_term;
    int          m_pend;

    calc_top dut_i (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .swp       (swp),
        .swd       (swd),
        .res_ready (res_ready),
        .res_valid (res_valid),
        .res_sign  (res_sign),
        .res_bcd   (res_bcd)
    );

    always #(PERIOD / 2) rst = ~rst;

    always @(posedge rst)
    begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT)
        begin
            $display("timeout: no result within %0d clock cycles", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    end

    // digit 0 at bit 1, digits 1 to 9 count down from bit 11
    function automatic calc_pkg::digit_keys_t digit_pattern(input int d);
        if (d == 0)
            return 12'b0000_0000_0010;
        return 12'b1 << (12 - d);
    endfunction

    function automatic calc_pkg::op_keys_t op_pattern(input int op);
        case (op)
            T_SUM:   return 8'b0100_0000;
            T_SUB:   return 8'b0010_0000;
            T_MUL:   return 8'b0001_0000;
            T_DIV:   return 8'b0000_1000;
            default: return 8'b0000_0001;
        endcase
    endfunction

    function automatic logic [31:0] apply_op(input int op, input logic [31:0] acc,
                                             input logic [31:0] term);
        case (op)
            T_SUM:   return acc + term;
            T_SUB:   return acc - term;
            T_MUL:   return acc * term;
            T_DIV:   return (term == 0) ? acc : acc / term;
            default: return acc;
        endcase
    endfunction

    task automatic press(input calc_pkg::digit_keys_t p, input calc_pkg::op_keys_t o,
                         input int hold);
        @(posedge rst);
        swp <= p;
        swd <= o;
        repeat (hold) @(posedge rst);
        swp <= '0;
        swd <= '0;
        @(posedge rst);
    endtask

    task automatic key_digit(input int d, input int hold);
        press(digit_pattern(d), '0, hold);
        m_term = m_term * 10 + d;
    endtask

    // the pending operator runs now, the new one waits
    task automatic key_op(input int op);
        press('0, op_pattern(op), 2);
        m_acc  = apply_op(m_pend, m_acc, m_term);
        m_term = '0;
        m_pend = op;
    endtask

    task automatic key_number(input int unsigned v, input int first_hold);
        int digs [10];
        int n;
        n = 0;
        do
        begin
            digs[n] = v % 10;
            v = v / 10;
            n++;
        end
        while (v != 0);
        for (int i = n - 1; i >= 0; i--)
            key_digit(digs[i], (i == n - 1) ? first_hold : 2);
    endtask

    // min, parens, unused digit bits and a two-key chord
    task automatic key_ignored();
        press('0, 8'b1000_0000, 2);
        press('0, 8'b0000_0100, 2);
        press('0, 8'b0000_0010, 2);
        press(12'b0000_0000_0101, '0, 2);
        press(12'b1100_0000_0000, '0, 2);
    endtask

    task automatic check_result(input int r, input logic [31:0] expv);
        logic           exp_sign;
        logic [31:0]    mag;
        calc_pkg::bcd_t exp_bcd;
        exp_sign = expv[31];
        mag      = exp_sign ? -expv : expv;
        exp_bcd  = '0;
        for (int i = 0; i < 10; i++)
        begin
            exp_bcd[4*i +: 4] = 4'(mag % 10);
            mag = mag / 10;
        end
        checks++;
        if (m_acc !== expv)
        begin
            errors++;
            $display("[FAIL] %0t row %0d: model gives %0d, table expects %0d",
                     $time, r, $signed(m_acc), $signed(expv));
        end
        if (res_sign !== exp_sign)
        begin
            errors++;
            $display("[FAIL] %0t row %0d: sign %b, expected %b", $time, r, res_sign, exp_sign);
        end
        if (res_bcd !== exp_bcd)
        begin
            errors++;
            $display("[FAIL] %0t row %0d: digits %h, expected %h", $time, r, res_bcd, exp_bcd);
        end
    endtask

    task automatic wait_result(input int r);
        int stall;
        stall = rows[r].stall;
        if (stall == RANDOM_STALL)
            stall = 1 + int'($unsigned($random(seed)) % 12);
        do
        begin
            @(negedge rst);
        end
        while (res_valid !== 1'b1);
        repeat (stall) @(posedge rst);
        @(posedge rst);
        res_ready <= 1'b1;
        @(negedge rst);
        check_result(r, 32'(rows[r].expv));
        @(posedge rst);
        res_ready <= 1'b0;
    endtask

    initial
    begin
        rst       = 1'b0;
        clk_100hz = 1'b1;
        swp       = '0;
        swd       = '0;
        res_ready = 1'b0;
        seed      = 32'hc707;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        m_acc     = '0;
        m_term    = '0;
        m_pend    = T_SUM;

        // a, op1, b, op2, c, sticky, hold, junk, stall, expected
        rows[0] = '{123, T_SUM, 45, T_NONE, 0, 1'b0, 2, 1'b0, 0, 168};
        rows[1] = '{7, T_SUB, 20, T_NONE, 0, 1'b0, 2, 1'b0, 3, -13};
        rows[2] = '{12, T_MUL, 34, T_NONE, 0, 1'b0, 30, 1'b0, 0, 408};
        rows[3] = '{100, T_DIV, 7, T_NONE, 0, 1'b0, 2, 1'b1, 1, 14};
        rows[4] = '{55, T_DIV, 0, T_NONE, 0, 1'b0, 2, 1'b0, 0, 55};
        rows[5] = '{5, T_SUM, 3, T_MUL, 2, 1'b0, 2, 1'b0, RANDOM_STALL, 16};
        // a is swallowed by the pending equ, acc carries over
        rows[6] = '{9, T_SUB, 30, T_NONE, 0, 1'b1, 2, 1'b0, 2, -14};
        rows[7] = '{99999, T_MUL, 99999, T_SUB, 2000000000, 1'b0, 2, 1'b1, RANDOM_STALL,
                    -590134591};

        repeat (3) @(posedge rst);
        clk_100hz <= 1'b0;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            if (!rows[r].sticky)
            begin
                // multiply by an empty term, then sum, clears the accumulator
                key_op(T_MUL);
                key_op(T_SUM);
            end
            key_number(rows[r].a, rows[r].hold);
            if (rows[r].junk)
                key_ignored();
            key_op(rows[r].op1);
            key_number(rows[r].b, 2);
            if (rows[r].op2 != T_NONE)
            begin
                key_op(rows[r].op2);
                key_number(rows[r].c, 2);
            end
            key_op(T_EQU);
            wait_result(r);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/calc_assert.sv ====
`default_nettype none

module calc_assert (
    input logic                  rst,
    input logic                  clk_100hz,
    input logic                  res_valid,
    input logic                  res_ready,
    input logic                  res_sign,
    input calc_pkg::bcd_t        res_bcd,
    input logic                  conv_start,
    input calc_pkg::ctrl_state_e state
);

    timeunit 1ns;
    timeprecision 1ps;

    a_valid_after_reset: assert property (@(posedge rst) clk_100hz |=> !res_valid)
        else $error("res_valid high right after reset");

    // result must not move while the consumer stalls
    a_hold_stable: assert property (@(posedge rst) disable iff (clk_100hz)
        res_valid && !res_ready |=> res_valid && $stable(res_sign) && $stable(res_bcd))
        else $error("result dropped or changed before acceptance");

    // no way back to apply straight from converting or holding
    a_no_restart: assert property (@(posedge rst) disable iff (clk_100hz)
        (state == calc_pkg::ST_CONVERT || state == calc_pkg::ST_HOLD) |=> !conv_start)
        else $error("conv_start right after converting or holding");

endmodule

bind calc_top calc_assert assert_i (
    .rst        (rst),
    .clk_100hz  (clk_100hz),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_sign   (res_sign),
    .res_bcd    (res_bcd),
    .conv_start (conv_start),
    .state      (u_calc_ctrl.state_q)
);

`default_nettype wire

// ==== design/calc_top.sv ====
`default_nettype none

module calc_top (
    input  logic                  rst,
    input  logic                  clk_100hz,
    input  calc_pkg::digit_keys_t swp,
    input  calc_pkg::op_keys_t    swd,
    input  logic                  res_ready,
    output logic                  res_valid,
    output logic                  res_sign,
    output calc_pkg::bcd_t        res_bcd
);

    calc_pkg::digit_t   digit;
    calc_pkg::opcode_t  opcode;
    logic               digit_hit;
    logic               op_hit;
    logic               term_shift;
    logic               op_apply;
    logic               conv_start;
    logic               conv_done;
    calc_pkg::operand_t acc;

    key_decoder u_key_decoder (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .swp       (swp),
        .swd       (swd),
        .digit     (digit),
        .opcode    (opcode),
        .digit_hit (digit_hit),
        .op_hit    (op_hit)
    );

    calc_ctrl u_calc_ctrl (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit_hit  (digit_hit),
        .op_hit     (op_hit),
        .opcode     (opcode),
        .conv_done  (conv_done),
        .res_ready  (res_ready),
        .term_shift (term_shift),
        .op_apply   (op_apply),
        .conv_start (conv_start),
        .res_valid  (res_valid)
    );

    term_alu u_term_alu (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .digit      (digit),
        .opcode     (opcode),
        .term_shift (term_shift),
        .op_apply   (op_apply),
        .acc        (acc)
    );

    bin_to_bcd u_bin_to_bcd (
        .rst        (rst),
        .clk_100hz  (clk_100hz),
        .conv_start (conv_start),
        .acc        (acc),
        .conv_done  (conv_done),
        .res_sign   (res_sign),
        .res_bcd    (res_bcd)
    );

endmodule

`default_nettype wire

// ==== design/bin_to_bcd.sv ====
`default_nettype none

module bin_to_bcd (
    input  logic               rst,
    input  logic               clk_100hz,
    input  logic               conv_start,
    input  calc_pkg::operand_t acc,
    output logic               conv_done,
    output logic               res_sign,
    output calc_pkg::bcd_t     res_bcd
);

    localparam int MSB = calc_pkg::OPERAND_W - 1;
    localparam logic [calc_pkg::STEP_W-1:0] LAST_STEP = calc_pkg::STEP_W'(MSB);

    logic                        busy;
    logic [calc_pkg::STEP_W-1:0] step;
    logic                        last;
    calc_pkg::operand_t          mag;
    calc_pkg::bcd_t              bcd_adj;

    // nibbles of 5 or more get 3 added before the shift
    function automatic calc_pkg::bcd_t add3(input calc_pkg::bcd_t v);
        calc_pkg::bcd_t r;
        r = v;
        for (int i = 0; i < calc_pkg::BCD_DIGITS; i++)
        begin
            if (r[4*i +: 4] >= 4'd5)
                r[4*i +: 4] = r[4*i +: 4] + 4'd3;
        end
        return r;
    endfunction

    assign bcd_adj = add3(res_bcd);
    assign last    = (step == LAST_STEP);

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            busy      <= 1'b0;
            step      <= '0;
            conv_done <= 1'b0;
        end
        else
        begin
            conv_done <= busy & last & ~conv_start;
            if (conv_start)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                if (last)
                    busy <= 1'b0;
            end
        end
    end

    // sign-magnitude on start, then one bit per cycle
    always_ff @(posedge rst)
    begin
        if (conv_start)
        begin
            res_sign <= acc[MSB];
            mag      <= acc[MSB] ? -acc : acc;
            res_bcd  <= '0;
        end
        else if (busy)
        begin
            res_bcd <= {bcd_adj[4*calc_pkg::BCD_DIGITS-2:0], mag[MSB]};
            mag     <= {mag[MSB-1:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== design/term_alu.sv ====
`default_nettype none

module term_alu (
    input  logic               rst,
    input  logic               clk_100hz,
    input  calc_pkg::digit_t   digit,
    input  calc_pkg::opcode_t  opcode,
    input  logic               term_shift,
    input  logic               op_apply,
    output calc_pkg::operand_t acc
);

    calc_pkg::operand_t term_q;
    calc_pkg::opcode_t  pend_op;
    calc_pkg::operand_t acc_next;
    calc_pkg::operand_t term_next;

    // decimal entry wraps mod 2^32
    assign term_next = term_q * calc_pkg::operand_t'(10) + calc_pkg::operand_t'(digit);

    always_comb
    begin
        acc_next = acc;
        case (pend_op)
            calc_pkg::OP_SUM:
                acc_next = acc + term_q;
            calc_pkg::OP_SUB:
                acc_next = acc - term_q;
            calc_pkg::OP_MUL:
                acc_next = acc * term_q;
            calc_pkg::OP_DIV:
                // x / 0 keeps acc
                if (term_q != '0)
                    acc_next = acc / term_q;
            default:
                acc_next = acc;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            acc     <= '0;
            term_q  <= '0;
            pend_op <= calc_pkg::OP_SUM;
        end
        else if (op_apply)
        begin
            // previous operator applies now, new one waits
            acc     <= acc_next;
            term_q  <= '0;
            pend_op <= opcode;
        end
        else if (term_shift)
            term_q <= term_next;
    end

endmodule

`default_nettype wire

// ==== design/calc_ctrl.sv ====
`default_nettype none

module calc_ctrl (
    input  logic              rst,
    input  logic              clk_100hz,
    input  logic              digit_hit,
    input  logic              op_hit,
    input  calc_pkg::opcode_t opcode,
    input  logic              conv_done,
    input  logic              res_ready,
    output logic              term_shift,
    output logic              op_apply,
    output logic              conv_start,
    output logic              res_valid
);

    calc_pkg::ctrl_state_e state_q;
    calc_pkg::ctrl_state_e state_d;
    logic                  in_entry;
    logic                  is_equ;

    assign in_entry = (state_q == calc_pkg::ST_ENTRY);
    assign is_equ   = (opcode == calc_pkg::OP_EQU);

    // keys only count while entering
    assign op_apply   = in_entry & op_hit;
    assign term_shift = in_entry & digit_hit & ~op_hit;

    // acc has settled by the time we sit in apply
    assign conv_start = (state_q == calc_pkg::ST_APPLY);
    assign res_valid  = (state_q == calc_pkg::ST_HOLD);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            calc_pkg::ST_ENTRY:
                if (op_hit && is_equ)
                    state_d = calc_pkg::ST_APPLY;
            calc_pkg::ST_APPLY:
                state_d = calc_pkg::ST_CONVERT;
            calc_pkg::ST_CONVERT:
                if (conv_done)
                    state_d = calc_pkg::ST_HOLD;
            calc_pkg::ST_HOLD:
                if (res_ready)
                    state_d = calc_pkg::ST_ENTRY;
            default:
                state_d = calc_pkg::ST_ENTRY;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            state_q <= calc_pkg::ST_ENTRY;
        else
            state_q <= state_d;
    end

endmodule

`default_nettype wire

// ==== design/key_decoder.sv ====
`default_nettype none

module key_decoder (
    input  logic                  rst,
    input  logic                  clk_100hz,
    input  calc_pkg::digit_keys_t swp,
    input  calc_pkg::op_keys_t    swd,
    output calc_pkg::digit_t      digit,
    output calc_pkg::opcode_t     opcode,
    output logic                  digit_hit,
    output logic                  op_hit
);

    calc_pkg::digit_t  digit_dec;
    calc_pkg::opcode_t op_dec;
    // bit 0 digit group, bit 1 operator group
    logic [1:0]        pres;
    logic [1:0]        pres_q;
    logic [1:0]        pres_qq;

    always_comb
    begin
        pres[0]   = 1'b1;
        digit_dec = 4'd0;
        case (swp)
            calc_pkg::KEY_D0: digit_dec = 4'd0;
            calc_pkg::KEY_D1: digit_dec = 4'd1;
            calc_pkg::KEY_D2: digit_dec = 4'd2;
            calc_pkg::KEY_D3: digit_dec = 4'd3;
            calc_pkg::KEY_D4: digit_dec = 4'd4;
            calc_pkg::KEY_D5: digit_dec = 4'd5;
            calc_pkg::KEY_D6: digit_dec = 4'd6;
            calc_pkg::KEY_D7: digit_dec = 4'd7;
            calc_pkg::KEY_D8: digit_dec = 4'd8;
            calc_pkg::KEY_D9: digit_dec = 4'd9;
            default:          pres[0] = 1'b0;
        endcase
    end

    // min and paren positions fall to default
    always_comb
    begin
        pres[1] = 1'b1;
        op_dec  = calc_pkg::OP_SUM;
        case (swd)
            calc_pkg::KEY_SUM: op_dec = calc_pkg::OP_SUM;
            calc_pkg::KEY_SUB: op_dec = calc_pkg::OP_SUB;
            calc_pkg::KEY_MUL: op_dec = calc_pkg::OP_MUL;
            calc_pkg::KEY_DIV: op_dec = calc_pkg::OP_DIV;
            calc_pkg::KEY_EQU: op_dec = calc_pkg::OP_EQU;
            default:           pres[1] = 1'b0;
        endcase
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            pres_q  <= 2'b00;
            pres_qq <= 2'b00;
        end
        else
        begin
            pres_q  <= pres;
            pres_qq <= pres_q;
        end
    end

    always_ff @(posedge rst)
    begin
        if (pres[0])
            digit <= digit_dec;
        if (pres[1])
            opcode <= op_dec;
    end

    // one pulse per press
    assign digit_hit = pres_q[0] & ~pres_qq[0];
    assign op_hit    = pres_q[1] & ~pres_qq[1];

endmodule

`default_nettype wire

// ==== design/calc_pkg.sv ====
`default_nettype none

package calc_pkg;

    localparam int DIGIT_KEYS = 12;
    localparam int OP_KEYS    = 8;
    localparam int OPERAND_W  = 32;
    localparam int BCD_DIGITS = 10;
    localparam int STEP_W     = $clog2(OPERAND_W);

    typedef logic [3:0]              digit_t;
    typedef logic [2:0]              opcode_t;
    typedef logic [OPERAND_W-1:0]    operand_t;
    typedef logic [4*BCD_DIGITS-1:0] bcd_t;
    typedef logic [DIGIT_KEYS-1:0]   digit_keys_t;
    typedef logic [OP_KEYS-1:0]      op_keys_t;

    localparam opcode_t OP_SUM = 3'd1;
    localparam opcode_t OP_SUB = 3'd2;
    localparam opcode_t OP_MUL = 3'd3;
    localparam opcode_t OP_DIV = 3'd4;
    localparam opcode_t OP_EQU = 3'd7;

    // keypad with digit 1 at the top bit
    localparam digit_keys_t KEY_D1 = 12'b1000_0000_0000;
    localparam digit_keys_t KEY_D2 = 12'b0100_0000_0000;
    localparam digit_keys_t KEY_D3 = 12'b0010_0000_0000;
    localparam digit_keys_t KEY_D4 = 12'b0001_0000_0000;
    localparam digit_keys_t KEY_D5 = 12'b0000_1000_0000;
    localparam digit_keys_t KEY_D6 = 12'b0000_0100_0000;
    localparam digit_keys_t KEY_D7 = 12'b0000_0010_0000;
    localparam digit_keys_t KEY_D8 = 12'b0000_0001_0000;
    localparam digit_keys_t KEY_D9 = 12'b0000_0000_1000;
    localparam digit_keys_t KEY_D0 = 12'b0000_0000_0010;

    localparam op_keys_t KEY_SUM = 8'b0100_0000;
    localparam op_keys_t KEY_SUB = 8'b0010_0000;
    localparam op_keys_t KEY_MUL = 8'b0001_0000;
    localparam op_keys_t KEY_DIV = 8'b0000_1000;
    localparam op_keys_t KEY_EQU = 8'b0000_0001;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_APPLY,
        ST_CONVERT,
        ST_HOLD
    } ctrl_state_e;

endpackage

`default_nettype wire
